//--- verilog/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  field_t;                  // Opcode or funct
    typedef logic [4:0]  shamt_t;

    // Coarse class from the opcode decoder
    typedef enum logic [1:0] {
        classAdd      = 2'b00,
        classSub      = 2'b01,
        classFunct    = 2'b10,
        classImmLogic = 2'b11
    } aluClass_t;

    typedef enum logic [3:0] {
        opAnd = 4'b0000,
        opOr  = 4'b0001,
        opAdd = 4'b0010,
        opSll = 4'b0011,
        opSrl = 4'b0100,
        opSra = 4'b0101,
        opSub = 4'b0110,
        opSlt = 4'b0111,
        opNor = 4'b1100,
        opXor = 4'b1101
    } aluOp_t;

    // Opcodes
    localparam field_t opcodeRType = 6'b000000;
    localparam field_t opcodeBeq   = 6'b000100;
    localparam field_t opcodeAddi  = 6'b001000;
    localparam field_t opcodeAddiu = 6'b001001;
    localparam field_t opcodeSlti  = 6'b001010;
    localparam field_t opcodeAndi  = 6'b001100;
    localparam field_t opcodeOri   = 6'b001101;
    localparam field_t opcodeXori  = 6'b001110;

    // Funct codes of R-type
    localparam field_t functSll  = 6'b000000;
    localparam field_t functSrl  = 6'b000010;
    localparam field_t functSra  = 6'b000011;
    localparam field_t functSllv = 6'b000100;
    localparam field_t functSrlv = 6'b000110;
    localparam field_t functAdd  = 6'b100000;
    localparam field_t functAddu = 6'b100001;
    localparam field_t functSub  = 6'b100010;
    localparam field_t functSubu = 6'b100011;
    localparam field_t functAnd  = 6'b100100;
    localparam field_t functOr   = 6'b100101;
    localparam field_t functXor  = 6'b100110;
    localparam field_t functNor  = 6'b100111;
    localparam field_t functSlt  = 6'b101010;

endpackage

//--- verilog/execCtrlIf.sv
`timescale 1ns/1ns

interface execCtrlIf;
    import mipsPkg::*;

    aluOp_t aluOp;
    logic   immSel;                                // Immediate is operand b
    logic   zeroExt;                               // Zero-extend instead of sign-extend
    logic   shamtSel;                              // Shamt field is operand a
    logic   regWrite;
    logic   destSel;                               // Destination is rd instead of rt
    logic   isBranch;
    logic   opIllegal;                             // Unknown opcode from the main decoder
    logic   illegal;                               // Combined flag

    // Both decoders drive their own members
    modport decoder (
        output aluOp, immSel, zeroExt, shamtSel, regWrite, destSel, isBranch,
        output opIllegal, illegal
    );

    modport datapath (
        input aluOp, immSel, zeroExt, shamtSel, regWrite, destSel, isBranch, illegal
    );

endinterface

//--- verilog/mainDecoder.sv
`timescale 1ns/1ns

module mainDecoder (
    input  mipsPkg::field_t    opcode,
    execCtrlIf.decoder         ctrl,
    output mipsPkg::aluClass_t aluClass
);
    import mipsPkg::*;

    always_comb
    begin
        aluClass       = classAdd;
        ctrl.immSel    = 1'b0;
        ctrl.zeroExt   = 1'b0;
        ctrl.destSel   = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.isBranch  = 1'b0;
        ctrl.opIllegal = 1'b0;
        case (opcode)
            opcodeRType:
            begin
                aluClass      = classFunct;        // Funct picks the operation
                ctrl.destSel  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opcodeAddi, opcodeAddiu:
            begin
                aluClass      = classAdd;
                ctrl.immSel   = 1'b1;              // Sign-extended immediate
                ctrl.regWrite = 1'b1;
            end
            opcodeBeq:
            begin
                aluClass      = classSub;          // Equal when difference is zero
                ctrl.isBranch = 1'b1;
            end
            opcodeAndi, opcodeOri, opcodeXori:
            begin
                aluClass      = classImmLogic;
                ctrl.immSel   = 1'b1;
                ctrl.zeroExt  = 1'b1;              // Logic immediates are unsigned
                ctrl.regWrite = 1'b1;
            end
            opcodeSlti:
            begin
                aluClass      = classImmLogic;
                ctrl.immSel   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default:
            begin
                ctrl.opIllegal = 1'b1;             // Unknown opcode
            end
        endcase
    end

endmodule

//--- verilog/aluControl.sv
`timescale 1ns/1ns

module aluControl (
    input  mipsPkg::aluClass_t aluClass,
    input  mipsPkg::field_t    funct,
    input  mipsPkg::field_t    opcode,
    input  logic               decodeIllegal,
    execCtrlIf.decoder         ctrl
);
    import mipsPkg::*;

    logic codeIllegal;                             // Funct or opcode not in the table

    always_comb
    begin
        ctrl.aluOp    = opAdd;
        ctrl.shamtSel = 1'b0;
        codeIllegal   = 1'b0;
        case (aluClass)
            classAdd:
            begin
                ctrl.aluOp = opAdd;
            end
            classSub:
            begin
                ctrl.aluOp = opSub;
            end
            classFunct:
            begin
                case (funct)
                    functAdd, functAddu: ctrl.aluOp = opAdd;
                    functSub, functSubu: ctrl.aluOp = opSub;
                    functAnd:            ctrl.aluOp = opAnd;
                    functOr:             ctrl.aluOp = opOr;
                    functNor:            ctrl.aluOp = opNor;
                    functXor:            ctrl.aluOp = opXor;
                    functSlt:            ctrl.aluOp = opSlt;
                    functSllv:           ctrl.aluOp = opSll;
                    functSrlv:           ctrl.aluOp = opSrl;
                    functSll:
                    begin
                        ctrl.aluOp    = opSll;
                        ctrl.shamtSel = 1'b1;      // Fixed shift amount
                    end
                    functSrl:
                    begin
                        ctrl.aluOp    = opSrl;
                        ctrl.shamtSel = 1'b1;
                    end
                    functSra:
                    begin
                        ctrl.aluOp    = opSra;
                        ctrl.shamtSel = 1'b1;
                    end
                    default:             codeIllegal = 1'b1;
                endcase
            end
            classImmLogic:
            begin
                case (opcode)
                    opcodeSlti:          ctrl.aluOp = opSlt;
                    opcodeAndi:          ctrl.aluOp = opAnd;
                    opcodeOri:           ctrl.aluOp = opOr;
                    opcodeXori:          ctrl.aluOp = opXor;
                    default:             codeIllegal = 1'b1;
                endcase
            end
        endcase
        ctrl.illegal = decodeIllegal | codeIllegal; // Single driver for the flag
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  mipsPkg::aluOp_t op,
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    output mipsPkg::word_t  result,
    output logic            zero
);
    import mipsPkg::*;

    shamt_t shiftAmount;
    logic   lessThan;

    assign shiftAmount = a[4:0];                   // Only the low five bits count
    assign lessThan    = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            opAnd:
                result = a & b;
            opOr:
                result = a | b;
            opNor:
                result = ~(a | b);
            opXor:
                result = a ^ b;
            opAdd:
                result = a + b;
            opSub:
                result = a - b;
            opSlt:
                result = {{31{1'b0}}, lessThan};
            opSll:
                result = b << shiftAmount;
            opSrl:
                result = b >> shiftAmount;
            opSra:
                result = $signed(b) >>> shiftAmount; // Sign bit fills in
            default:
                result = '0;
        endcase
    end

    assign zero = (result == '0);                  // BEQ looks at this after SUB

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ns

module registerFile #(
    parameter int regCount = 32
) (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::regAddr_t readAddrA,
    input  mipsPkg::regAddr_t readAddrB,
    output mipsPkg::word_t    readDataA,
    output mipsPkg::word_t    readDataB,
    input  logic              writeEn,
    input  mipsPkg::regAddr_t writeAddr,
    input  mipsPkg::word_t    writeData
);
    import mipsPkg::*;

    word_t regs [1:regCount-1];                    // Register zero is not stored
    logic  hitA;
    logic  hitB;
    logic  hitWrite;

    // Index zero and indices past regCount read as zero
    assign hitA     = (readAddrA != '0) && (int'(readAddrA) < regCount);
    assign hitB     = (readAddrB != '0) && (int'(readAddrB) < regCount);
    assign hitWrite = writeEn && (writeAddr != '0) && (int'(writeAddr) < regCount);

    assign readDataA = hitA ? regs[readAddrA] : '0;
    assign readDataB = hitB ? regs[readAddrB] : '0;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 1; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (hitWrite)
        begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

//--- verilog/executeCore.sv
`timescale 1ns/1ns

module executeCore #(
    parameter int regCount = 32
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instrValid,
    input  mipsPkg::instr_t   instr,
    output logic              wbValid,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData,
    output logic              illegal,
    output logic              branchTaken
);
    import mipsPkg::*;

    field_t      opcode;
    field_t      funct;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    shamt_t      shamt;
    logic [15:0] imm;
    word_t       immExt;
    aluClass_t   aluClass;
    word_t       readDataA;
    word_t       readDataB;
    word_t       aluA;
    word_t       aluB;
    word_t       aluResult;
    logic        aluZero;
    regAddr_t    destAddr;
    logic        writeEn;

    execCtrlIf ctrlBus ();

    // Instruction fields
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    mainDecoder i_mainDecoder (
        .opcode   (opcode),
        .ctrl     (ctrlBus),
        .aluClass (aluClass)
    );

    aluControl i_aluControl (
        .aluClass      (aluClass),
        .funct         (funct),
        .opcode        (opcode),
        .decodeIllegal (ctrlBus.opIllegal),
        .ctrl          (ctrlBus)
    );

    assign immExt = ctrlBus.zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign aluA   = ctrlBus.shamtSel ? {27'b0, shamt} : readDataA;
    assign aluB   = ctrlBus.immSel ? immExt : readDataB;

    assign destAddr = ctrlBus.destSel ? rd : rt;
    assign writeEn  = instrValid & ctrlBus.regWrite & ~ctrlBus.illegal; // Illegal words never write

    registerFile #(
        .regCount (regCount)
    ) i_registerFile (
        .clk       (clk),
        .arstN     (arstN),
        .readAddrA (rs),
        .readAddrB (rt),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (writeEn),
        .writeAddr (destAddr),
        .writeData (aluResult)
    );

    alu i_alu (
        .op     (ctrlBus.aluOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    // One-cycle pulses with address and data at zero when idle
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wbValid     <= 1'b0;
            wbAddr      <= '0;
            wbData      <= '0;
            illegal     <= 1'b0;
            branchTaken <= 1'b0;
        end
        else
        begin
            wbValid     <= writeEn;
            wbAddr      <= writeEn ? destAddr : '0;
            wbData      <= writeEn ? aluResult : '0;
            illegal     <= instrValid & ctrlBus.illegal;
            branchTaken <= instrValid & ctrlBus.isBranch & aluZero;
        end
    end

endmodule

//--- verification/executeCore_properties.sv
`timescale 1ns/1ns

module executeCoreProperties (
    input logic              clk,
    input logic              arstN,
    input logic              instrValid,
    input logic              wbValid,
    input mipsPkg::regAddr_t wbAddr,
    input logic              illegal,
    input logic              branchTaken
);

    // One kind of result per instruction
    resultsExclusive: assert property (
        @(posedge clk) disable iff (!arstN)
        $onehot0({illegal, branchTaken, wbValid})
    ) else $error("illegal, branchTaken and wbValid are high together");

    quietAfterIdle: assert property (
        @(posedge clk) disable iff (!arstN)
        !instrValid |=> !(illegal || branchTaken || wbValid)
    ) else $error("an output pulsed without a strobe in the cycle before");

    addrOnlyWithValid: assert property (
        @(posedge clk) disable iff (!arstN)
        !wbValid |-> (wbAddr == '0)
    ) else $error("wbAddr is nonzero while wbValid is low");

endmodule

bind executeCore executeCoreProperties i_executeCoreProperties (
    .clk         (clk),
    .arstN       (arstN),
    .instrValid  (instrValid),
    .wbValid     (wbValid),
    .wbAddr      (wbAddr),
    .illegal     (illegal),
    .branchTaken (branchTaken)
);

//--- verification/executeCoreChecker.sv
`timescale 1ns/1ns

module executeCoreChecker (
    input  logic              clk,
    input  logic              arstN,
    input  logic              expStrobe,
    input  logic              expIllegal,
    input  logic              expBranch,
    input  logic              expWbValid,
    input  mipsPkg::regAddr_t expWbAddr,
    input  mipsPkg::word_t    expWbData,
    input  logic              illegal,
    input  logic              branchTaken,
    input  logic              wbValid,
    input  mipsPkg::regAddr_t wbAddr,
    input  mipsPkg::word_t    wbData,
    output int                errorCount,
    output int                checkCount
);
    import mipsPkg::*;

    logic     strobeQ;
    logic     illegalQ;
    logic     branchQ;
    logic     wbValidQ;
    regAddr_t wbAddrQ;
    word_t    wbDataQ;
    int       errors = 0;
    int       checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // Expected outputs one cycle after the strobe and zero when idle
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            strobeQ  <= 1'b0;
            illegalQ <= 1'b0;
            branchQ  <= 1'b0;
            wbValidQ <= 1'b0;
            wbAddrQ  <= '0;
            wbDataQ  <= '0;
        end
        else
        begin
            strobeQ  <= expStrobe;
            illegalQ <= expStrobe & expIllegal;
            branchQ  <= expStrobe & expBranch;
            wbValidQ <= expStrobe & expWbValid;
            wbAddrQ  <= expStrobe ? expWbAddr : '0;
            wbDataQ  <= expStrobe ? expWbData : '0;
        end
    end

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // DUT outputs move on the rising edge and are steady by the falling one
    always @(negedge clk)
    begin
        if (arstN)
        begin
            if (strobeQ)
            begin
                checks++;
            end
            compareField("illegal", {31'b0, illegal}, {31'b0, illegalQ});
            compareField("branchTaken", {31'b0, branchTaken}, {31'b0, branchQ});
            compareField("wbValid", {31'b0, wbValid}, {31'b0, wbValidQ});
            compareField("wbAddr", {27'b0, wbAddr}, {27'b0, wbAddrQ});
            compareField("wbData", wbData, wbDataQ);
        end
    end

endmodule

//--- verification/executeCoreTb.sv
`timescale 1ns/1ns

module executeCoreTb;
    import mipsPkg::*;

    localparam int    clkPeriod   = 8;
    localparam int    resetCycles = 4;
    localparam int    drainLimit  = 16;                // Cycles allowed for the last result
    localparam int    runLimit    = 4000;              // Limit for the whole run in cycles
    localparam string vectorFile  = "verification/executeCoreVectors.txt";

    logic     clk;
    logic     arstN;
    logic     instrValid;
    instr_t   instr;
    logic     wbValid;
    regAddr_t wbAddr;
    word_t    wbData;
    logic     illegal;
    logic     branchTaken;

    // Expected outputs handed to the checker with each strobe
    logic     expStrobe;
    logic     expIllegal;
    logic     expBranch;
    logic     expWbValid;
    regAddr_t expWbAddr;
    word_t    expWbData;

    int       errorCount;
    int       checkCount;
    int       strobeCount;
    logic     aborted;

    executeCore #(.regCount (32)) i_executeCore (.*);

    executeCoreChecker i_executeCoreChecker (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    initial
    begin
        #(clkPeriod * runLimit);
        $display("Timeout: the simulation ran past %0d cycles", runLimit);
        $display("TEST FAILED");
        $finish;
    end

    task automatic idleCycles(input int count);
        instrValid = 1'b0;
        expStrobe  = 1'b0;
        repeat (count) @(negedge clk);
    endtask

    task automatic applyReset();
        instrValid = 1'b0;
        expStrobe  = 1'b0;
        arstN      = 1'b0;
        repeat (resetCycles) @(negedge clk);
        arstN      = 1'b1;
    endtask

    task automatic driveInstruction(
        input instr_t   word,
        input logic     wantIllegal,
        input logic     wantBranch,
        input logic     wantWbValid,
        input regAddr_t wantWbAddr,
        input word_t    wantWbData
    );
        instr       = word;
        instrValid  = 1'b1;
        expStrobe   = 1'b1;
        expIllegal  = wantIllegal;
        expBranch   = wantBranch;
        expWbValid  = wantWbValid;
        expWbAddr   = wantWbAddr;
        expWbData   = wantWbData;
        strobeCount++;
        @(negedge clk);
    endtask

    initial
    begin
        int               fd;
        int               fields;
        int               gap;
        int               stall;
        logic [31:0]      vInstr;
        logic [31:0]      vIllegal;
        logic [31:0]      vBranch;
        logic [31:0]      vWbValid;
        logic [31:0]      vWbAddr;
        logic [31:0]      vWbData;
        logic [8*128-1:0] lineBuf;
        logic [8*5-1:0]   keyword;

        instrValid  = 1'b0;
        instr       = '0;
        arstN       = 1'b0;
        expStrobe   = 1'b0;
        expIllegal  = 1'b0;
        expBranch   = 1'b0;
        expWbValid  = 1'b0;
        expWbAddr   = '0;
        expWbData   = '0;
        strobeCount = 0;
        aborted     = 1'b0;

        applyReset();
        fd = $fopen(vectorFile, "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file %s", vectorFile);
            aborted = 1'b1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                lineBuf = '0;
                fields  = $fgets(lineBuf, fd);
                fields  = $sscanf(lineBuf, "%h %d %h %h %h %d %h", vInstr, gap, vIllegal,
                                  vBranch, vWbValid, vWbAddr, vWbData);
                keyword = '0;
                if (fields != 7)
                begin
                    fields = $sscanf(lineBuf, "%s", keyword);
                end
                if (fields == 7)
                begin
                    idleCycles(gap);
                    driveInstruction(vInstr, vIllegal[0], vBranch[0], vWbValid[0],
                                     vWbAddr[4:0], vWbData);
                end
                else if (keyword == "reset")
                begin
                    idleCycles(1);                     // Last result drains first
                    applyReset();
                end
            end
            $fclose(fd);
        end

        idleCycles(0);
        stall = 0;
        while (checkCount < strobeCount && stall < drainLimit)
        begin
            @(posedge clk);
            stall++;
        end
        if (checkCount < strobeCount)
        begin
            $display("Stalled: the checker saw %0d of %0d results", checkCount, strobeCount);
            aborted = 1'b1;
        end
        if (strobeCount == 0)
        begin
            $display("No instruction was read from %s", vectorFile);
            aborted = 1'b1;
        end

        $display("Finished with %0d errors over %0d checked results", errorCount, checkCount);
        if (aborted || errorCount != 0)
        begin
            $display("TEST FAILED");
        end
        else
        begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

//--- verification/executeCoreVectors.txt
// instr  gap  illegal  branchTaken  wbValid  wbAddr  wbData
// Gap counts idle cycles before the strobe, wbAddr is decimal
20010005 0 0 0 1 1  00000005  // addi  r1, r0, 5
2002fffd 0 0 0 1 2  fffffffd  // addi  r2, r0, -3
24038000 0 0 0 1 3  ffff8000  // addiu r3, r0, 0x8000 sign-extends
34048001 0 0 0 1 4  00008001  // ori   r4, r0, 0x8001 zero-extends
3045ff0f 0 0 0 1 5  0000ff0d  // andi  r5, r2, 0xff0f
3826ffff 0 0 0 1 6  0000fffa  // xori  r6, r1, 0xffff
28470001 0 0 0 1 7  00000001  // slti  r7, r2, 1
2828ffff 0 0 0 1 8  00000000  // slti  r8, r1, -1
00224820 0 0 0 1 9  00000002  // add   r9, r1, r2
00865021 0 0 0 1 10 00017ffb  // addu  r10, r4, r6
00225822 0 0 0 1 11 00000008  // sub   r11, r1, r2
00416023 0 0 0 1 12 fffffff8  // subu  r12, r2, r1
00a66824 0 0 0 1 13 0000ff08  // and   r13, r5, r6
00647025 0 0 0 1 14 ffff8001  // or    r14, r3, r4
00277827 0 0 0 1 15 fffffffa  // nor   r15, r1, r7
00468026 0 0 0 1 16 ffff0007  // xor   r16, r2, r6
0041882a 0 0 0 1 17 00000001  // slt   r17, r2, r1 signed
00019900 0 0 0 1 19 00000050  // sll   r19, r1, 4
0003a202 0 0 0 1 20 00ffff80  // srl   r20, r3, 8
0003aa03 0 0 0 1 21 ffffff80  // sra   r21, r3, 8
00c1b004 0 0 0 1 22 14000000  // sllv  r22, r1, r6 by 26
0043b806 0 0 0 1 23 00000007  // srlv  r23, r3, r2 by 29
20180007 1 0 0 1 24 00000007  // addi  r24, r0, 7
0318c820 0 0 0 1 25 0000000e  // add   r25, r24, r24 right behind
20200009 0 0 0 1 0  0000000e  // addi  r0, r1, 9
0001d021 0 0 0 1 26 00000005  // addu  r26, r0, r1 with r0 still zero
10210003 0 0 1 0 0  00000000  // beq   r1, r1 taken
10220003 0 0 0 0 0  00000000  // beq   r1, r2 not taken
10080001 0 0 1 0 0  00000000  // beq   r0, r8 taken
fc010001 0 1 0 0 0  00000000  // opcode 0x3f
8c010000 0 1 0 0 0  00000000  // lw is not covered
00420808 0 1 0 0 0  00000000  // funct 0x08 with rd r1
0020d821 2 0 0 1 27 00000005  // addu  r27, r1, r0 sees r1 unchanged
reset                         // Clears outputs and registers
0026e021 1 0 0 1 28 00000000  // addu  r28, r1, r6
0070e825 0 0 0 1 29 00000000  // or    r29, r3, r16

//--- sources.f
verilog/mipsPkg.sv
verilog/execCtrlIf.sv
verilog/mainDecoder.sv
verilog/aluControl.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/executeCore.sv
verification/executeCore_properties.sv
verification/executeCoreChecker.sv
verification/executeCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the execute core testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module executeCoreTb -f sources.f -o executeCoreSim

./obj_dir/executeCoreSim | tee "$logFile"

if grep -q "TEST FAILED" "$logFile"; then
    echo "Simulation failed, see $logFile"
    exit 1
fi
echo "Simulation passed"
